//--- compile.f
hdl/game_video_pkg.sv
hdl/spi_frame_receiver.sv
hdl/command_decoder.sv
hdl/target_ring.sv
hdl/vga_timing.sv
hdl/octagon_layer.sv
hdl/pixel_compositor.sv
hdl/game_video_top.sv
dv/video_checker.sv
dv/game_video_tb.sv

//--- Makefile
# Verilator build and run for the game display testbench
VERILATOR ?= verilator
TOP       ?= game_video_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/game_video_tb.sv
// testbench for the game display, sends random command frames during vertical blanking
// the video_checker instance models the picture and compares every output cycle
`timescale 1ns/1ps
`default_nettype none

module game_video_tb;

  localparam int     run_frames   = 8;
  localparam int     clk_half_ns  = 4;
  localparam int     reset_cycles = 16;
  localparam longint frame_cycles = longint'(game_video_pkg::h_total) *
                                    longint'(game_video_pkg::v_total);
  // eight frames at 8 ns per cycle, plus 10 percent
  localparam longint watchdog_ns  = run_frames * frame_cycles * 2 * clk_half_ns * 11 / 10;

  logic                   pxl_clk;
  logic                   reset;
  logic                   sck;
  logic                   sdi;
  logic                   fsync;
  logic                   hsync;
  logic                   vsync;
  logic                   sync_b;
  logic [7:0]             r;
  logic [7:0]             g;
  logic [7:0]             b;
  logic [31:0]            sent_word;
  logic                   sent_valid;
  logic                   done;
  game_video_pkg::coord_t model_line;
  int                     check_count;
  int                     error_count;
  logic [15:0]            lfsr_state;
  longint                 cycles;
  int                     words_sent;
  int                     frames_cut;

  game_video_top dut0 (
    .pxl_clk(pxl_clk), .reset(reset), .sck(sck), .sdi(sdi), .fsync(fsync),
    .hsync(hsync), .vsync(vsync), .sync_b(sync_b), .r(r), .g(g), .b(b)
  );

  video_checker check0 (
    .pxl_clk(pxl_clk), .reset(reset), .hsync(hsync), .vsync(vsync), .sync_b(sync_b),
    .r(r), .g(g), .b(b), .sent_word(sent_word), .sent_valid(sent_valid), .done(done),
    .model_line(model_line), .check_count(check_count), .error_count(error_count)
  );

  initial begin
    pxl_clk = 1'b0;
  end

  always #(clk_half_ns) pxl_clk = ~pxl_clk;

  always @(posedge pxl_clk) begin
    cycles <= reset ? 64'd0 : cycles + 64'd1;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  task automatic step(input int n);
    repeat (n) begin
      @(posedge pxl_clk);
      #1;
    end
  endtask

  // nbits below 32 makes a frame that fsync cuts short
  task automatic make_word(output logic [31:0] w, output int nbits);
    logic [2:0]  kind;
    logic [2:0]  sub;
    logic [31:0] body;
    kind  = 3'(take_bits(3));
    body  = take_bits(30);
    nbits = 32;
    case (kind)
      3'd0, 3'd1: w = {2'b00, body[29:0]};
      3'd2, 3'd3: w = {2'b01, body[29:0]};
      3'd4, 3'd5: begin
        w     = {2'b11, body[29:0]};
        w[29] = body[29] | take_bits(1) != 32'd0;
      end
      default: begin
        sub = 3'(take_bits(3));
        case (sub)
          3'd0:       w = 32'h8000_0000;
          3'd1:       w = 32'h8000_0001;
          3'd2, 3'd3: w = {3'b101, body[28:0]};
          default: begin
            w     = {2'b11, body[29:0]};
            nbits = int'(take_bits(5));
          end
        endcase
      end
    endcase
  endtask

  task automatic send_frame(input logic [31:0] w, input int nbits);
    fsync = 1'b1;
    if (nbits == 32) begin
      sent_word  = w;
      sent_valid = 1'b1;
    end
    step(1);
    sent_valid = 1'b0;
    step(3);
    for (int i = 31; i > 31 - nbits; i--) begin
      sdi = w[i];
      step(4);
      sck = 1'b1;
      step(4);
      sck = 1'b0;
    end
    step(4);
    fsync = 1'b0;
    step(4);
  endtask

  initial begin
    logic [31:0] w;
    int          nbits;
    lfsr_state = 16'd70;
    reset      = 1'b1;
    sck        = 1'b0;
    sdi        = 1'b0;
    fsync      = 1'b0;
    sent_word  = '0;
    sent_valid = 1'b0;
    done       = 1'b0;
    words_sent = 0;
    frames_cut = 0;
    repeat (reset_cycles) @(posedge pxl_clk);
    #1;
    reset = 1'b0;
    while (cycles < run_frames * frame_cycles) begin
      // a frame started by line 35 is decoded before line 37
      if ((model_line >= game_video_pkg::v_active_start + game_video_pkg::active_height ||
           model_line < game_video_pkg::v_active_start - 10'd1) && take_bits(2) == 32'd0) begin
        make_word(w, nbits);
        send_frame(w, nbits);
        if (nbits == 32) begin
          words_sent++;
        end else begin
          frames_cut++;
        end
      end else begin
        step(400);
      end
    end
    done = 1'b1;
    step(2);
    $display("summary: %0d checks, %0d errors, %0d words sent, %0d frames cut short",
             check_count, error_count, words_sent, frames_cut);
    if (error_count == 0 && check_count > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog: the run did not finish within %0d ns", watchdog_ns);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/video_checker.sv
// reference model of the game display, fed with every complete word the testbench sends
// compares sync levels and pixel color with the DUT on each falling clock edge
`timescale 1ns/1ps
`default_nettype none

module video_checker (
  input  logic                   pxl_clk,
  input  logic                   reset,
  input  logic                   hsync,
  input  logic                   vsync,
  input  logic                   sync_b,
  input  logic [7:0]             r,
  input  logic [7:0]             g,
  input  logic [7:0]             b,
  input  logic [31:0]            sent_word,
  input  logic                   sent_valid,
  input  logic                   done,
  output game_video_pkg::coord_t model_line,
  output int                     check_count,
  output int                     error_count
);

  localparam int n_tests     = 6;
  localparam int cat_raster  = 0;
  localparam int cat_blank   = 1;
  localparam int cat_bar     = 2;
  localparam int cat_cursor  = 3;
  localparam int cat_target  = 4;
  localparam int cat_special = 5;
  localparam int max_printed = 50;

  // model of game state and the target ring
  game_video_pkg::target_t slots [8];
  logic [2:0]             start_ptr;
  logic [2:0]             end_ptr;
  logic [7:0]             cur_time;
  game_video_pkg::coord_t mouse_x;
  game_video_pkg::coord_t mouse_y;
  logic [7:0]             health;
  logic [31:0]            pending [$];
  bit                     special_batch;
  bit                     frame_special;

  // model raster and the expected registered outputs
  game_video_pkg::coord_t hcnt;
  game_video_pkg::coord_t vcnt;
  logic                   exp_hsync;
  logic                   exp_vsync;
  logic                   exp_sync_b;
  game_video_pkg::color_t exp_color;
  int                     exp_cat;
  bit                     exp_special;
  bit                     primed = 1'b0;

  int    checks [n_tests] = '{default: 0};
  int    errors [n_tests] = '{default: 0};
  int    total_checks = 0;
  int    total_errors = 0;
  int    printed = 0;
  string test_names [n_tests] = '{"raster_timing", "blanking_background", "health_bar",
                                  "timer_cursor", "targets", "ignored_restart"};

  assign model_line  = vcnt;
  assign check_count = total_checks;
  assign error_count = total_errors;

  task automatic clear_ring();
    for (int k = 0; k < 8; k++) begin
      slots[k] = '0;
    end
    start_ptr = '0;
    end_ptr   = '0;
  endtask

  task automatic apply_word(input logic [31:0] w);
    game_video_pkg::target_t e;
    if (w == 32'h8000_0000) begin
      clear_ring();
      special_batch = 1'b1;
    end else if (w[31:30] == 2'b00) begin
      health = w[29:22];
    end else if (w[31:30] == 2'b01) begin
      cur_time = w[29:22];
      mouse_x  = w[21:12];
      mouse_y  = w[11:2];
    end else if (w[31:30] == 2'b11) begin
      e.active      = w[29];
      e.x           = w[28:19];
      e.y           = w[18:9];
      e.target_time = cur_time + 8'd60;
      // active entries join at the end, inactive ones retire the oldest slot
      if (e.active) begin
        slots[end_ptr] = e;
        end_ptr        = end_ptr + 3'd1;
      end else begin
        slots[start_ptr] = e;
        start_ptr        = start_ptr + 3'd1;
      end
    end else begin
      special_batch = 1'b1;
    end
  endtask

  // 0 no cover, 1 core or ring, 2 white rim
  function automatic int octagon_hit(input int x, input int y, input game_video_pkg::target_t t);
    int         dx;
    int         dy;
    int         s;
    int         card;
    int         diag;
    int         m;
    int         ring;
    logic [7:0] remaining;
    dx   = (x > int'(t.x)) ? x - int'(t.x) : int'(t.x) - x;
    dy   = (y > int'(t.y)) ? y - int'(t.y) : int'(t.y) - y;
    s    = (dx + dy) % (1 << game_video_pkg::coord_w);
    card = (dx > dy) ? dx : dy;
    diag = s - s / 4 - s / 32;
    m    = (card > diag) ? card : diag;
    // time left until the target, modulo 256
    remaining = t.target_time - cur_time;
    ring      = int'(remaining) + 25;
    if (m < 25 || (m > ring && m < ring + 5)) begin
      return 1;
    end
    return (m < 30) ? 2 : 0;
  endfunction

  task automatic expect_pixel(input game_video_pkg::coord_t h, input game_video_pkg::coord_t v,
                              output game_video_pkg::color_t c, output int cat);
    int  x;
    int  y;
    int  hit;
    int  dx;
    int  dy;
    bit  found;
    c     = '0;
    cat   = cat_blank;
    found = 1'b0;
    x     = int'(h) - int'(game_video_pkg::h_active_start);
    y     = int'(v) - int'(game_video_pkg::v_active_start);
    if (x < 0 || x >= 640 || y < 0 || y >= 480) begin
      return;
    end
    c = game_video_pkg::bg_color;
    for (int k = 0; k < 8; k++) begin
      hit = slots[start_ptr + 3'(k)].active ? octagon_hit(x, y, slots[start_ptr + 3'(k)]) : 0;
      if (!found && hit != 0) begin
        found = 1'b1;
        c     = (hit == 1) ? game_video_pkg::target_color : game_video_pkg::rim_color;
        cat   = cat_target;
      end
    end
    if (x >= 50 && x < 305 && y >= 20 && y < 30) begin
      c   = (x < 50 + int'(health)) ? game_video_pkg::bar_full_color
                                    : game_video_pkg::bar_empty_color;
      cat = cat_bar;
    end
    dx = (x > int'(mouse_x)) ? x - int'(mouse_x) : int'(mouse_x) - x;
    dy = (y > int'(mouse_y)) ? y - int'(mouse_y) : int'(mouse_y) - y;
    if ((dx <= 6 && dy <= 1) || (dx <= 1 && dy <= 6)) begin
      c   = game_video_pkg::cursor_color;
      cat = cat_cursor;
    end
  endtask

  task automatic compare(input string name, input logic [7:0] got, input logic [7:0] want,
                         input int cat);
    bit special;
    special = exp_special && cat != cat_raster;
    checks[cat]++;
    total_checks++;
    if (special) begin
      checks[cat_special]++;
    end
    if (got !== want) begin
      errors[cat]++;
      total_errors++;
      if (special) begin
        errors[cat_special]++;
      end
      if (printed < max_printed) begin
        $display("FAIL time %0t signal %s expected %02h got %02h", $time, name, want, got);
        printed++;
        if (printed == max_printed) begin
          $display("further mismatches are counted but not printed");
        end
      end
    end
  endtask

  always @(posedge pxl_clk) begin : model_step
    game_video_pkg::color_t c;
    int cat;
    if (sent_valid) begin
      pending.push_back(sent_word);
    end
    primed <= 1'b1;
    if (reset) begin
      clear_ring();
      pending.delete();
      cur_time      = '0;
      mouse_x       = '0;
      mouse_y       = '0;
      health        = '0;
      frame_special = 1'b0;
      hcnt        <= '0;
      vcnt        <= '0;
      exp_hsync   <= 1'b1;
      exp_vsync   <= 1'b1;
      exp_sync_b  <= 1'b1;
      exp_color   <= '0;
      exp_cat     <= cat_blank;
      exp_special <= 1'b0;
    end else begin
      // all words of the blanking interval take effect before the first visible line
      if (hcnt == 10'd0 && vcnt == game_video_pkg::v_active_start) begin
        special_batch = 1'b0;
        while (pending.size() > 0) begin
          apply_word(pending.pop_front());
        end
        frame_special = special_batch;
      end
      expect_pixel(hcnt, vcnt, c, cat);
      exp_hsync   <= !(hcnt >= game_video_pkg::h_sync_start && hcnt < game_video_pkg::h_sync_end);
      exp_vsync   <= !(vcnt >= game_video_pkg::v_sync_start && vcnt < game_video_pkg::v_sync_end);
      exp_sync_b  <= !(hcnt >= game_video_pkg::h_sync_start && hcnt < game_video_pkg::h_sync_end) &&
                     !(vcnt >= game_video_pkg::v_sync_start && vcnt < game_video_pkg::v_sync_end);
      exp_color   <= c;
      exp_cat     <= cat;
      exp_special <= frame_special;
      if (hcnt == game_video_pkg::h_total - 10'd1) begin
        hcnt <= '0;
        vcnt <= (vcnt == game_video_pkg::v_total - 10'd1) ? 10'd0 : vcnt + 10'd1;
      end else begin
        hcnt <= hcnt + 10'd1;
      end
    end
  end

  // registered outputs and expectations are both stable at the falling edge
  always @(negedge pxl_clk) begin
    if (primed && !done) begin
      compare("hsync", {7'd0, hsync}, {7'd0, exp_hsync}, cat_raster);
      compare("vsync", {7'd0, vsync}, {7'd0, exp_vsync}, cat_raster);
      compare("sync_b", {7'd0, sync_b}, {7'd0, exp_sync_b}, cat_raster);
      compare("r", r, exp_color.r, exp_cat);
      compare("g", g, exp_color.g, exp_cat);
      compare("b", b, exp_color.b, exp_cat);
    end
  end

  always @(posedge done) begin
    for (int k = 0; k < n_tests; k++) begin
      $display("test %s: %0d checks, %0d errors, %s", test_names[k], checks[k], errors[k],
               (errors[k] == 0) ? "ok" : "failed");
    end
  end

endmodule

`default_nettype wire

//--- hdl/game_video_top.sv
// display side of the rhythm-target game, serial commands in and VGA video out
// everything runs on pxl_clk, video outputs lag the raster counters by one cycle
`timescale 1ns/1ps
`default_nettype none

module game_video_top (
  input  logic       pxl_clk,
  input  logic       reset,
  input  logic       sck,
  input  logic       sdi,
  input  logic       fsync,
  output logic       hsync,
  output logic       vsync,
  output logic       sync_b,
  output logic [7:0] r,
  output logic [7:0] g,
  output logic [7:0] b
);

  logic [game_video_pkg::word_w-1:0] word;
  logic                              word_valid;
  game_video_pkg::game_state_t       state;
  game_video_pkg::target_t           entry;
  logic                              push;
  logic                              clear;
  game_video_pkg::target_t [game_video_pkg::ring_depth-1:0] targets;
  game_video_pkg::pixel_pos_t        pos;
  logic                              hsync_raw;
  logic                              vsync_raw;
  game_video_pkg::color_t            layer_color;

  spi_frame_receiver u_rx (
    .pxl_clk(pxl_clk), .reset(reset), .sck(sck), .sdi(sdi), .fsync(fsync),
    .word(word), .word_valid(word_valid)
  );

  command_decoder u_dec (
    .pxl_clk(pxl_clk), .reset(reset), .word(word), .word_valid(word_valid),
    .state(state), .entry(entry), .push(push), .clear(clear)
  );

  target_ring u_ring (
    .pxl_clk(pxl_clk), .reset(reset), .push(push), .clear(clear),
    .entry(entry), .targets(targets)
  );

  vga_timing u_timing (
    .pxl_clk(pxl_clk), .reset(reset), .pos(pos),
    .hsync_raw(hsync_raw), .vsync_raw(vsync_raw)
  );

  octagon_layer u_octagons (
    .pos(pos), .targets(targets), .current_time(state.current_time), .color(layer_color)
  );

  pixel_compositor u_comp (
    .pxl_clk(pxl_clk), .reset(reset), .pos(pos), .state(state), .color_in(layer_color),
    .hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
    .hsync(hsync), .vsync(vsync), .sync_b(sync_b), .r(r), .g(g), .b(b)
  );

endmodule

`default_nettype wire

//--- hdl/pixel_compositor.sv
// adds health bar and mouse cross over the target layer, blanks outside the window
// and registers color with the sync levels so all video outputs share one cycle of delay
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor (
  input  logic                        pxl_clk,
  input  logic                        reset,
  input  game_video_pkg::pixel_pos_t  pos,
  input  game_video_pkg::game_state_t state,
  input  game_video_pkg::color_t      color_in,
  input  logic                        hsync_raw,
  input  logic                        vsync_raw,
  output logic                        hsync,
  output logic                        vsync,
  output logic                        sync_b,
  output logic [7:0]                  r,
  output logic [7:0]                  g,
  output logic [7:0]                  b
);

  game_video_pkg::coord_t d_x;
  game_video_pkg::coord_t d_y;
  logic                   in_bar;
  logic                   bar_filled;
  logic                   on_cursor;
  game_video_pkg::color_t pixel;

  assign in_bar = pos.x >= game_video_pkg::bar_x &&
                  pos.x <  game_video_pkg::bar_x + game_video_pkg::bar_len &&
                  pos.y >= game_video_pkg::bar_y &&
                  pos.y <  game_video_pkg::bar_y + game_video_pkg::bar_height;
  assign bar_filled = pos.x < game_video_pkg::bar_x + {2'b00, state.health};

  // cross is a long arm on one axis and a thin one on the other
  assign d_x = (pos.x > state.mouse_x) ? pos.x - state.mouse_x : state.mouse_x - pos.x;
  assign d_y = (pos.y > state.mouse_y) ? pos.y - state.mouse_y : state.mouse_y - pos.y;
  assign on_cursor =
    (d_x <= game_video_pkg::cursor_arm && d_y <= game_video_pkg::cursor_half_width) ||
    (d_x <= game_video_pkg::cursor_half_width && d_y <= game_video_pkg::cursor_arm);

  always_comb begin
    pixel = color_in;
    if (in_bar) begin
      pixel = bar_filled ? game_video_pkg::bar_full_color : game_video_pkg::bar_empty_color;
    end
    if (on_cursor) begin
      pixel = game_video_pkg::cursor_color;
    end
    if (!pos.in_active) begin
      pixel = '0;
    end
  end

  always_ff @(posedge pxl_clk) begin
    if (reset) begin
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      sync_b <= 1'b1;
      r      <= '0;
      g      <= '0;
      b      <= '0;
    end else begin
      hsync  <= hsync_raw;
      vsync  <= vsync_raw;
      sync_b <= hsync_raw & vsync_raw;
      r      <= pixel.r;
      g      <= pixel.g;
      b      <= pixel.b;
    end
  end

endmodule

`default_nettype wire

//--- hdl/octagon_layer.sv
// draws the target octagons with their shrinking alignment rings over the background
// purely combinational, lower ring index (older target) is drawn on top
`timescale 1ns/1ps
`default_nettype none

module octagon_layer (
  input  game_video_pkg::pixel_pos_t                               pos,
  input  game_video_pkg::target_t [game_video_pkg::ring_depth-1:0] targets,
  input  logic [game_video_pkg::time_w-1:0]                        current_time,
  output game_video_pkg::color_t                                   color
);

  logic [game_video_pkg::ring_depth-1:0] hit;
  game_video_pkg::color_t hit_color [game_video_pkg::ring_depth];

  for (genvar k = 0; k < game_video_pkg::ring_depth; k++) begin : g_target
    game_video_pkg::coord_t d_x;
    game_video_pkg::coord_t d_y;
    game_video_pkg::coord_t s;
    game_video_pkg::coord_t card;
    game_video_pkg::coord_t diag;
    game_video_pkg::coord_t m;
    game_video_pkg::coord_t ring;
    logic                   in_core;
    logic                   in_ring;

    assign d_x = (pos.x > targets[k].x) ? pos.x - targets[k].x : targets[k].x - pos.x;
    assign d_y = (pos.y > targets[k].y) ? pos.y - targets[k].y : targets[k].y - pos.y;

    // octagon distance, the diagonal sum is scaled by about 1 - 1/4 - 1/32
    assign s    = d_x + d_y;
    assign card = (d_x > d_y) ? d_x : d_y;
    assign diag = s - {2'b00, s[9:2]} - {5'b00000, s[9:5]};
    assign m    = (card > diag) ? card : diag;

    // ring shrinks toward the core as the target time approaches
    assign ring = {2'b00, targets[k].target_time - current_time} +
                  game_video_pkg::core_radius;

    assign in_core = m < game_video_pkg::core_radius;
    assign in_ring = m > ring && m < ring + game_video_pkg::ring_thickness;

    assign hit[k] = targets[k].active &&
                    (in_core || in_ring || m < game_video_pkg::rim_radius);
    assign hit_color[k] = (in_core || in_ring) ? game_video_pkg::target_color
                                               : game_video_pkg::rim_color;
  end

  // walk from the newest slot down so the oldest covering target wins
  always_comb begin
    color = game_video_pkg::bg_color;
    for (int k = game_video_pkg::ring_depth - 1; k >= 0; k--) begin
      if (hit[k]) begin
        color = hit_color[k];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/vga_timing.sv
// 800x525 raster counters with active-low sync levels
// pos gives coordinates relative to the 640x480 display window
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
  input  logic                       pxl_clk,
  input  logic                       reset,
  output game_video_pkg::pixel_pos_t pos,
  output logic                       hsync_raw,
  output logic                       vsync_raw
);

  game_video_pkg::coord_t hcnt;
  game_video_pkg::coord_t vcnt;
  logic                   line_start;
  logic                   h_active;
  logic                   v_active;

  // last pixel of the line, next clock starts a new one
  assign line_start = (hcnt == game_video_pkg::h_total - 1'b1);

  always_ff @(posedge pxl_clk) begin
    if (reset) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (line_start) begin
      hcnt <= '0;
      if (vcnt == game_video_pkg::v_total - 1'b1) begin
        vcnt <= '0;
      end else begin
        vcnt <= vcnt + 1'b1;
      end
    end else begin
      hcnt <= hcnt + 1'b1;
    end
  end

  assign hsync_raw = ~(hcnt >= game_video_pkg::h_sync_start &&
                       hcnt <  game_video_pkg::h_sync_end);
  assign vsync_raw = ~(vcnt >= game_video_pkg::v_sync_start &&
                       vcnt <  game_video_pkg::v_sync_end);

  assign h_active = hcnt >= game_video_pkg::h_active_start &&
                    hcnt <  game_video_pkg::h_active_start + game_video_pkg::active_width;
  assign v_active = vcnt >= game_video_pkg::v_active_start &&
                    vcnt <  game_video_pkg::v_active_start + game_video_pkg::active_height;

  // outside the window x and y wrap, the compositor blanks those pixels
  assign pos.x         = hcnt - game_video_pkg::h_active_start;
  assign pos.y         = vcnt - game_video_pkg::v_active_start;
  assign pos.in_active = h_active && v_active;

endmodule

`default_nettype wire

//--- hdl/target_ring.sv
// eight-entry ring of targets, active entries append at end, inactive retire at start
// targets[0] is always the slot at the start pointer
`timescale 1ns/1ps
`default_nettype none

module target_ring (
  input  logic                    pxl_clk,
  input  logic                    reset,
  input  logic                    push,
  input  logic                    clear,
  input  game_video_pkg::target_t entry,
  output game_video_pkg::target_t [game_video_pkg::ring_depth-1:0] targets
);

  game_video_pkg::target_t slots [game_video_pkg::ring_depth];
  logic [game_video_pkg::ptr_w-1:0] start_ptr;
  logic [game_video_pkg::ptr_w-1:0] end_ptr;

  always_ff @(posedge pxl_clk) begin
    if (reset || clear) begin
      for (int k = 0; k < game_video_pkg::ring_depth; k++) begin
        slots[k] <= '0;
      end
      start_ptr <= '0;
      end_ptr   <= '0;
    end else if (push) begin
      if (entry.active) begin
        slots[end_ptr] <= entry;
        end_ptr        <= end_ptr + 1'b1;
      end else begin
        slots[start_ptr] <= entry;
        start_ptr        <= start_ptr + 1'b1;
      end
    end
  end

  // rotate so the oldest target comes first, pointer arithmetic wraps mod 8
  always_comb begin
    logic [game_video_pkg::ptr_w-1:0] idx;
    idx = start_ptr;
    for (int k = 0; k < game_video_pkg::ring_depth; k++) begin
      targets[k] = slots[idx];
      idx        = idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/command_decoder.sv
// decodes host command words into game state, target entries and restart
// target entries are combinational with word_valid, state updates a cycle later
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
  input  logic                              pxl_clk,
  input  logic                              reset,
  input  logic [game_video_pkg::word_w-1:0] word,
  input  logic                              word_valid,
  output game_video_pkg::game_state_t       state,
  output game_video_pkg::target_t           entry,
  output logic                              push,
  output logic                              clear
);

  game_video_pkg::cmd_kind_e kind;

  always_comb begin
    if (word == game_video_pkg::restart_word) begin
      kind = game_video_pkg::cmd_restart;
    end else begin
      case (word[31:30])
        2'b00:   kind = game_video_pkg::cmd_status;
        2'b01:   kind = game_video_pkg::cmd_timer;
        2'b11:   kind = game_video_pkg::cmd_target;
        // game over, roll and other top-bit 10 words
        default: kind = game_video_pkg::cmd_ignored;
      endcase
    end
  end

  always_ff @(posedge pxl_clk) begin
    if (reset) begin
      state <= '0;
      clear <= 1'b0;
    end else begin
      clear <= word_valid && (kind == game_video_pkg::cmd_restart);
      if (word_valid && kind == game_video_pkg::cmd_status) begin
        // score bits 21:0 are not displayed
        state.health <= word[29:22];
      end
      if (word_valid && kind == game_video_pkg::cmd_timer) begin
        state.current_time <= word[29:22];
        state.mouse_x      <= word[21:12];
        state.mouse_y      <= word[11:2];
      end
    end
  end

  // target time is a fixed lead past the current game time
  assign entry.active      = word[29];
  assign entry.x           = word[28:19];
  assign entry.y           = word[18:9];
  assign entry.target_time = state.current_time + game_video_pkg::target_lead;

  assign push = word_valid && (kind == game_video_pkg::cmd_target);

endmodule

`default_nettype wire

//--- hdl/spi_frame_receiver.sv
// framed serial receiver, samples sck/sdi/fsync in the pixel clock domain
// emits each complete 32-bit word MSB first with a one-cycle word_valid
`timescale 1ns/1ps
`default_nettype none

module spi_frame_receiver (
  input  logic                              pxl_clk,
  input  logic                              reset,
  input  logic                              sck,
  input  logic                              sdi,
  input  logic                              fsync,
  output logic [game_video_pkg::word_w-1:0] word,
  output logic                              word_valid
);

  // pin order is {fsync, sck, sdi}
  logic [2:0] pin_meta;
  logic [2:0] pin_sync;
  logic       sck_prev;
  logic       sck_rise;
  logic       fsync_s;
  logic       sdi_s;
  logic [game_video_pkg::word_w-2:0] shift;
  logic [$clog2(game_video_pkg::word_w)-1:0] bit_cnt;

  always_ff @(posedge pxl_clk) begin
    pin_meta <= {fsync, sck, sdi};
    pin_sync <= pin_meta;
  end

  assign fsync_s  = pin_sync[2];
  assign sdi_s    = pin_sync[0];
  assign sck_rise = pin_sync[1] & ~sck_prev;

  always_ff @(posedge pxl_clk) begin
    if (reset) begin
      sck_prev   <= 1'b0;
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      sck_prev   <= pin_sync[1];
      word_valid <= 1'b0;
      if (!fsync_s) begin
        // a short frame is dropped here
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (&bit_cnt) begin
          word_valid <= 1'b1;
        end
      end
    end
  end

  // data shift register, first bit ends up in the MSB
  always_ff @(posedge pxl_clk) begin
    if (fsync_s && sck_rise) begin
      shift <= {shift[game_video_pkg::word_w-3:0], sdi_s};
      if (&bit_cnt) begin
        word <= {shift, sdi_s};
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/game_video_pkg.sv
// shared raster constants, command encodings, colors and bus types for the game display
// design files refer to everything here by package-scoped name
`default_nettype none

package game_video_pkg;

  localparam int coord_w    = 10;
  localparam int time_w     = 8;
  localparam int word_w     = 32;
  localparam int ring_depth = 8;
  localparam int ptr_w      = 3;

  typedef logic [coord_w-1:0] coord_t;

  // raster in pixel clocks and lines, syncs are low inside [start, end)
  localparam coord_t h_total        = 10'd800;
  localparam coord_t v_total        = 10'd525;
  localparam coord_t h_sync_start   = 10'd8;
  localparam coord_t h_sync_end     = 10'd104;
  localparam coord_t v_sync_start   = 10'd2;
  localparam coord_t v_sync_end     = 10'd4;
  localparam coord_t h_active_start = 10'd152;
  localparam coord_t v_active_start = 10'd37;
  localparam coord_t active_width   = 10'd640;
  localparam coord_t active_height  = 10'd480;

  // target drawing
  localparam logic [time_w-1:0] target_lead = 8'd60;
  localparam coord_t core_radius    = 10'd25;
  localparam coord_t rim_radius     = 10'd30;
  localparam coord_t ring_thickness = 10'd5;

  // health bar and cursor geometry
  localparam coord_t bar_x             = 10'd50;
  localparam coord_t bar_y             = 10'd20;
  localparam coord_t bar_len           = 10'd255;
  localparam coord_t bar_height        = 10'd10;
  localparam coord_t cursor_arm        = 10'd6;
  localparam coord_t cursor_half_width = 10'd1;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } color_t;

  localparam color_t bg_color        = 24'h808080;
  localparam color_t target_color    = 24'h8080FF;
  localparam color_t rim_color       = 24'hFFFFFF;
  localparam color_t bar_full_color  = 24'hFFFFFF;
  localparam color_t bar_empty_color = 24'h000000;
  localparam color_t cursor_color    = 24'hFF4040;

  // low codes mirror the top two bits of the word
  typedef enum logic [2:0] {
    cmd_status  = 3'b000,
    cmd_timer   = 3'b001,
    cmd_target  = 3'b011,
    cmd_restart = 3'b100,
    cmd_ignored = 3'b111
  } cmd_kind_e;

  localparam logic [word_w-1:0] restart_word = 32'h8000_0000;

  typedef struct packed {
    logic                active;
    coord_t              x;
    coord_t              y;
    logic [time_w-1:0]   target_time;
  } target_t;

  typedef struct packed {
    logic [time_w-1:0]   current_time;
    coord_t              mouse_x;
    coord_t              mouse_y;
    logic [time_w-1:0]   health;
  } game_state_t;

  typedef struct packed {
    coord_t              x;
    coord_t              y;
    logic                in_active;
  } pixel_pos_t;

endpackage

`default_nettype wire
